//--- verilog.f
logic/capturePkg.sv
logic/sourceTiming.sv
logic/captureWindow.sv
logic/lineBuffer.sv
logic/outputReader.sv
logic/captureTop.sv
test/captureTestbench.sv

//--- run.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module captureTestbench --Mdir obj_dir -o captureSim -f verilog.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/captureSim > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -qx "TEST PASSED" "$logFile"; then
    exit 0
else
    echo "Pass message not found in $logFile"
    exit 1
fi

//--- test/captureTestbench.sv
module captureTestbench;
    import capturePkg::*;

    localparam int frameCount   = 7;
    localparam int frameClocks  = hTotal * vTotal * 2;
    localparam int watchdogTime = (frameCount + 2) * frameClocks * 8;

    logic                  clock;
    logic                  nreset;
    logic                  pixelStrobe;
    logic                  hsync;
    logic                  vsync;
    logic [7:0]            red;
    logic [7:0]            green;
    logic [7:0]            blue;
    logic                  lineDoubler;
    logic [pixelWidth-1:0] pixelOut;
    logic                  pixelValid;
    logic                  startTrigger;
    logic                  readerBusy;

    // one row per frame: name, mode, colour tag, random blue.
    string      frameName    [frameCount] = '{"progBasic", "progSecond", "progRandom",
                                              "dblAfterProg", "dblSecond", "dblRandom",
                                              "progAfterDbl"};
    logic       frameDoubled [frameCount] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0};
    logic [7:0] frameTag     [frameCount] = '{8'ha1, 8'hb2, 8'h00, 8'hc3, 8'hd4, 8'h00, 8'he5};
    logic       frameRandom  [frameCount] = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0};

    logic [7:0]            blueTable [vTotal][hTotal];
    logic [pixelWidth-1:0] expected  [ramWords];
    integer                seed;
    int                    errorCount;
    logic                  frameDone;

    captureTop uut (
        .clock        (clock),
        .nreset       (nreset),
        .pixelStrobe  (pixelStrobe),
        .hsync        (hsync),
        .vsync        (vsync),
        .red          (red),
        .green        (green),
        .blue         (blue),
        .lineDoubler  (lineDoubler),
        .pixelOut     (pixelOut),
        .pixelValid   (pixelValid),
        .startTrigger (startTrigger),
        .readerBusy   (readerBusy)
    );

    always #4 clock = ~clock;

    task automatic fillBlue(input int idx);
        int x;
        int y;
        for (y = 0; y < vTotal; y++) begin
            for (x = 0; x < hTotal; x++) begin
                blueTable[y][x] = frameRandom[idx] ? 8'($random(seed)) : frameTag[idx];
            end
        end
    endtask

    // word at each address is line base plus offset into the window.
    task automatic buildExpected(input int idx);
        int hStart;
        int vStart;
        int a;
        int x;
        int y;
        hStart = frameDoubled[idx] ? dblHStart : progHStart;
        vStart = frameDoubled[idx] ? dblVStart : progVStart;
        for (a = 0; a < ramWords; a++) begin
            x = hStart + a % lineLength;
            y = vStart + a / lineLength;
            expected[a] = {8'(x), 8'(y), blueTable[y][x]};
        end
    endtask

    // strobe every second clock; data follows the counter by one pixel.
    task automatic driveFrame(input int idx);
        int x;
        int y;
        lineDoubler = frameDoubled[idx];
        for (y = 0; y < vTotal; y++) begin
            for (x = 0; x < hTotal; x++) begin
                @(posedge clock);
                #1;
                pixelStrobe = 1'b1;
                hsync       = (x == 0);
                vsync       = (x == 0) && (y == 0);
                @(posedge clock);
                #1;
                pixelStrobe = 1'b0;
                hsync       = 1'b0;
                vsync       = 1'b0;
                red         = 8'(x);
                green       = 8'(y);
                blue        = blueTable[y][x];
            end
        end
        frameDone = 1'b1;
    endtask

    task automatic watchFrame(input int idx);
        int cycle;
        int triggerCount;
        int triggerCycle;
        int validCount;
        int firstValid;
        int lastValid;
        int busyCount;
        cycle        = 0;
        triggerCount = 0;
        triggerCycle = 0;
        validCount   = 0;
        firstValid   = 0;
        lastValid    = 0;
        busyCount    = 0;
        while (!frameDone) begin
            @(negedge clock);
            cycle++;
            if (startTrigger) begin
                triggerCount++;
                triggerCycle = cycle;
            end
            if (readerBusy) begin
                busyCount++;
            end
            if (pixelValid) begin
                if (validCount == 0) begin
                    firstValid = cycle;
                end
                lastValid = cycle;
                if (validCount < ramWords && pixelOut !== expected[validCount]) begin
                    $display("Mismatch %s word %0d: expected %h, actual %h",
                        frameName[idx], validCount, expected[validCount], pixelOut);
                    errorCount++;
                end
                validCount++;
            end
        end
        if (triggerCount == 0) begin
            $display("Frame %s never raised a start trigger.", frameName[idx]);
            errorCount++;
        end else if (triggerCount != 1) begin
            $display("Mismatch %s trigger count: expected 1, actual %0d",
                frameName[idx], triggerCount);
            errorCount++;
        end else if (validCount > 0 && firstValid - triggerCycle != 2) begin
            $display("Mismatch %s trigger to first word: expected 2, actual %0d",
                frameName[idx], firstValid - triggerCycle);
            errorCount++;
        end
        if (validCount != ramWords) begin
            $display("Mismatch %s valid words: expected %0d, actual %0d",
                frameName[idx], ramWords, validCount);
            errorCount++;
        end else if (lastValid - firstValid + 1 != validCount) begin
            $display("Frame %s output stream had a gap in pixelValid.", frameName[idx]);
            errorCount++;
        end
        // busy for one cycle per buffer read.
        if (busyCount != ramWords) begin
            $display("Mismatch %s busy cycles: expected %0d, actual %0d",
                frameName[idx], ramWords, busyCount);
            errorCount++;
        end
        if (readerBusy) begin
            $display("Reader was still busy at the end of frame %s.", frameName[idx]);
            errorCount++;
        end
    endtask

    // outputs stay quiet before any pixel arrives.
    task automatic checkIdle();
        repeat (10) begin
            @(negedge clock);
            if (pixelValid || startTrigger || readerBusy) begin
                $display("Outputs were active after reset with no input.");
                errorCount++;
            end
        end
    endtask

    initial begin
        int i;
        clock       = 1'b0;
        nreset      = 1'b0;
        pixelStrobe = 1'b0;
        hsync       = 1'b0;
        vsync       = 1'b0;
        red         = '0;
        green       = '0;
        blue        = '0;
        lineDoubler = 1'b0;
        seed        = 32'h8d16;
        errorCount  = 0;
        frameDone   = 1'b0;
        repeat (4) @(posedge clock);
        #1;
        nreset = 1'b1;
        checkIdle();
        for (i = 0; i < frameCount; i++) begin
            fillBlue(i);
            buildExpected(i);
            frameDone = 1'b0;
            fork
                driveFrame(i);
                watchFrame(i);
            join
        end
        $display("Frames: %0d, errors: %0d", frameCount, errorCount);
        if (errorCount == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(watchdogTime);
        $display("Watchdog expired before all frames were checked.");
        $display("TEST FAILED");
        $finish;
    end

endmodule

//--- logic/captureTop.sv
module captureTop (
    input  logic                              clock,
    input  logic                              nreset,
    input  logic                              pixelStrobe,
    input  logic                              hsync,
    input  logic                              vsync,
    input  logic [7:0]                        red,
    input  logic [7:0]                        green,
    input  logic [7:0]                        blue,
    input  logic                              lineDoubler,
    output logic [capturePkg::pixelWidth-1:0] pixelOut,
    output logic                              pixelValid,
    output logic                              startTrigger,
    output logic                              readerBusy
);
    import capturePkg::*;

    logic [counterWidth-1:0] counterX;
    logic [counterWidth-1:0] counterY;
    logic [pixelWidth-1:0]   wrData;
    logic [addrWidth-1:0]    wrAddr;
    logic                    wrEnable;
    logic [addrWidth-1:0]    rdAddr;
    logic [pixelWidth-1:0]   rdData;

    sourceTiming timing (
        .clock       (clock),
        .nreset      (nreset),
        .pixelStrobe (pixelStrobe),
        .hsync       (hsync),
        .vsync       (vsync),
        .counterX    (counterX),
        .counterY    (counterY)
    );

    captureWindow capture (
        .clock        (clock),
        .nreset       (nreset),
        .red          (red),
        .green        (green),
        .blue         (blue),
        .counterX     (counterX),
        .counterY     (counterY),
        .lineDoubler  (lineDoubler),
        .wrData       (wrData),
        .wrAddr       (wrAddr),
        .wrEnable     (wrEnable),
        .startTrigger (startTrigger)
    );

    lineBuffer buffer (
        .clock    (clock),
        .wrEnable (wrEnable),
        .wrAddr   (wrAddr),
        .wrData   (wrData),
        .rdAddr   (rdAddr),
        .rdData   (rdData)
    );

    outputReader reader (
        .clock        (clock),
        .nreset       (nreset),
        .startTrigger (startTrigger),
        .rdData       (rdData),
        .rdAddr       (rdAddr),
        .pixelOut     (pixelOut),
        .pixelValid   (pixelValid),
        .readerBusy   (readerBusy)
    );

endmodule

//--- logic/outputReader.sv
module outputReader (
    input  logic                              clock,
    input  logic                              nreset,
    input  logic                              startTrigger,
    input  logic [capturePkg::pixelWidth-1:0] rdData,
    output logic [capturePkg::addrWidth-1:0]  rdAddr,
    output logic [capturePkg::pixelWidth-1:0] pixelOut,
    output logic                              pixelValid,
    output logic                              readerBusy
);
    import capturePkg::*;

    readerState state;

    always_ff @(posedge clock) begin
        if (!nreset) begin
            state      <= readerIdle;
            rdAddr     <= '0;
            pixelValid <= 1'b0;
        end else begin
            // follows the RAM read latency by one cycle.
            pixelValid <= (state == readerRun);

            case (state)
                readerIdle: begin
                    if (startTrigger) begin
                        state  <= readerRun;
                        rdAddr <= '0;
                    end
                end
                readerRun: begin
                    if (rdAddr == addrWidth'(ramWords - 1)) begin
                        state  <= readerIdle;
                        rdAddr <= '0;
                    end else begin
                        rdAddr <= rdAddr + 1'b1;
                    end
                end
                default: begin
                    state <= readerIdle;
                end
            endcase
        end
    end

    assign pixelOut   = rdData;
    assign readerBusy = (state == readerRun);

    // a read run starts only from idle on a start trigger.
    assert property (@(posedge clock) disable iff (!nreset)
        $rose(pixelValid) |-> $past(startTrigger, 2) && $past(state, 2) == readerIdle)
        else $error("pixelValid rose without a start trigger");

endmodule

//--- logic/lineBuffer.sv
module lineBuffer (
    input  logic                              clock,
    input  logic                              wrEnable,
    input  logic [capturePkg::addrWidth-1:0]  wrAddr,
    input  logic [capturePkg::pixelWidth-1:0] wrData,
    input  logic [capturePkg::addrWidth-1:0]  rdAddr,
    output logic [capturePkg::pixelWidth-1:0] rdData
);
    import capturePkg::*;

    logic [pixelWidth-1:0] memory [ramWords];

    always_ff @(posedge clock) begin
        if (wrEnable) begin
            memory[wrAddr] <= wrData;
        end
    end

    // one cycle read latency.
    always_ff @(posedge clock) begin
        rdData <= memory[rdAddr];
    end

endmodule

//--- logic/captureWindow.sv
module captureWindow (
    input  logic                                clock,
    input  logic                                nreset,
    input  logic [7:0]                          red,
    input  logic [7:0]                          green,
    input  logic [7:0]                          blue,
    input  logic [capturePkg::counterWidth-1:0] counterX,
    input  logic [capturePkg::counterWidth-1:0] counterY,
    input  logic                                lineDoubler,
    output logic [capturePkg::pixelWidth-1:0]   wrData,
    output logic [capturePkg::addrWidth-1:0]    wrAddr,
    output logic                                wrEnable,
    output logic                                startTrigger
);
    import capturePkg::*;

    logic [counterWidth-1:0] hStart;
    logic [counterWidth-1:0] hEnd;
    logic [counterWidth-1:0] vStart;
    logic [counterWidth-1:0] vEnd;
    logic [addrWidth-1:0]    triggerAddr;
    logic [addrWidth-1:0]    lineBase;
    logic [counterWidth-1:0] counterXPrev;
    logic [counterWidth-1:0] fullAddr;
    logic [counterWidth-1:0] lineIndex;
    logic                    inVertical;
    logic                    inWindow;
    logic                    firstBuffer;
    logic                    atTrigger;

    always_comb begin
        if (lineDoubler) begin
            hStart      = counterWidth'(dblHStart);
            hEnd        = counterWidth'(dblHEnd);
            vStart      = counterWidth'(dblVStart);
            vEnd        = counterWidth'(dblVEnd);
            triggerAddr = addrWidth'(dblTriggerAddr);
        end else begin
            hStart      = counterWidth'(progHStart);
            hEnd        = counterWidth'(progHEnd);
            vStart      = counterWidth'(progVStart);
            vEnd        = counterWidth'(progVEnd);
            triggerAddr = addrWidth'(progTriggerAddr);
        end
    end

    assign inVertical = (counterY >= vStart) && (counterY < vEnd);
    assign inWindow   = inVertical && (counterX >= hStart) && (counterX < hEnd);

    // base of the current line plus offset into the window.
    assign fullAddr = counterWidth'(lineBase) + (counterX - hStart);

    // lines above the window wrap to large values and fail the check.
    assign lineIndex   = counterY - vStart;
    assign firstBuffer = lineIndex < counterWidth'(bufferLines);
    assign atTrigger   = firstBuffer && (fullAddr[addrWidth-1:0] == triggerAddr);

    always_ff @(posedge clock) begin
        if (!nreset) begin
            wrEnable     <= 1'b0;
            wrAddr       <= '0;
            startTrigger <= 1'b0;
            lineBase     <= '0;
            counterXPrev <= '0;
        end else begin
            counterXPrev <= counterX;

            // once per line, while the counter sits on the window end.
            if (counterXPrev == hEnd && counterX == hEnd) begin
                if (inVertical && lineBase < ramWords - lineLength) begin
                    lineBase <= lineBase + addrWidth'(lineLength);
                end else begin
                    lineBase <= '0;
                end
            end

            wrEnable <= inWindow;
            if (inWindow) begin
                wrAddr <= fullAddr[addrWidth-1:0];
            end

            // each word is written twice, so keep the pulse to one cycle.
            startTrigger <= inWindow && atTrigger && !startTrigger;
        end
    end

    always_ff @(posedge clock) begin
        if (inWindow) begin
            wrData <= {red, green, blue};
        end
    end

    // the accumulated line base must keep every write inside the RAM.
    assert property (@(posedge clock) disable iff (!nreset)
        inWindow |-> fullAddr < ramWords)
        else $error("write address beyond ramWords");

endmodule

//--- logic/sourceTiming.sv
module sourceTiming (
    input  logic                              clock,
    input  logic                              nreset,
    input  logic                              pixelStrobe,
    input  logic                              hsync,
    input  logic                              vsync,
    output logic [capturePkg::counterWidth-1:0] counterX,
    output logic [capturePkg::counterWidth-1:0] counterY
);
    import capturePkg::*;

    // syncs arrive together with the strobe of pixel 0.
    always_ff @(posedge clock) begin
        if (!nreset) begin
            counterX <= '0;
            counterY <= '0;
        end else if (pixelStrobe) begin
            if (vsync) begin
                counterX <= '0;
                counterY <= '0;
            end else if (hsync) begin
                counterX <= '0;
                counterY <= counterY + 1'b1;
            end else begin
                counterX <= counterX + 1'b1;
            end
        end
    end

    // a missing hsync would run past the line length.
    assert property (@(posedge clock) disable iff (!nreset)
        counterX < hTotal)
        else $error("counterX reached hTotal without an hsync");

    assert property (@(posedge clock) disable iff (!nreset)
        counterY < vTotal)
        else $error("counterY reached vTotal without a vsync");

    // line base advance downstream relies on the counters holding two cycles.
    assert property (@(posedge clock) disable iff (!nreset)
        pixelStrobe |=> !pixelStrobe)
        else $error("pixel strobes on adjacent cycles");

endmodule

//--- logic/capturePkg.sv
package capturePkg;

    // source frame geometry, blanking included.
    localparam int hTotal = 24;
    localparam int vTotal = 14;

    // progressive capture window.
    localparam int progHStart = 4;
    localparam int progHEnd   = 20;
    localparam int progVStart = 2;
    localparam int progVEnd   = 10;

    // line-doubled capture window, shifted right and down.
    localparam int dblHStart = 6;
    localparam int dblHEnd   = 22;
    localparam int dblVStart = 3;
    localparam int dblVEnd   = 11;

    // buffer layout.
    localparam int lineLength  = 16;
    localparam int ramWords    = 128;
    localparam int addrWidth   = 7;
    localparam int bufferLines = 8;

    // last word of the frame in both modes.
    localparam int progTriggerAddr = 127;
    localparam int dblTriggerAddr  = 127;

    localparam int counterWidth = 12;
    localparam int pixelWidth   = 24;

    typedef enum logic {
        readerIdle,
        readerRun
    } readerState;

endpackage
